// File: Makefile
# Verilator build and run for the LED bar meter

VERILATOR  ?= verilator
TOP        := led_bar_tb
FILELIST   := filelist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST FAIL
PASS_MSG   := TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation finished cleanly"; \
	else \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/led_bar_sva.sv
`default_nettype none

module led_bar_sva (
    input logic                clk,
    input logic                pb_out_rst,
    input logic                press_clear,
    input bar_pkg::led_t       led,
    input bar_pkg::bar_state_e state
);
    timeunit 1ns;
    timeprecision 100ps;

    bar_pkg::led_t led_n;

    assign led_n = ~led; // unlit leds, must be a low-side run of ones

    // lit leds form one block from bit 15 down
    a_thermometer: assert property (@(posedge clk)
        (led_n & (led_n + bar_pkg::led_t'(1))) == '0)
        else $error("led is not a thermometer pattern: %h", led);

    a_one_step: assert property (@(posedge clk) disable iff (pb_out_rst)
        !press_clear |=> $countones(led ^ $past(led)) <= 1)
        else $error("more than one led changed without a clear");

    a_full_state: assert property (@(posedge clk)
        (state == bar_pkg::BAR_FULL) == (&led))
        else $error("state and full bar disagree, led %h", led);

    a_reset_dark: assert property (@(posedge clk) pb_out_rst |-> led == '0)
        else $error("led not dark during reset");

endmodule

bind led_bar_ctrl led_bar_sva u_sva (
    .clk         (clk),
    .pb_out_rst  (pb_out_rst),
    .press_clear (press_clear),
    .led         (led),
    .state       (state)
);

`default_nettype wire

// File: dv/led_bar_tb.sv
`default_nettype none

`include "bar_params.svh"

module led_bar_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 10;
    localparam int DEPTH      = `DEBOUNCE_DEPTH;
    localparam int HOLD       = 2 * DEPTH + 2;  // press and release length each
    localparam int GLITCHES   = 3;
    localparam int ROW_CYCLES = 2 * HOLD + GLITCHES * (2 * DEPTH - 1) + DEPTH + 2;
    localparam int RST_CYCLES = 8;
    localparam int MAX_ROWS   = 64;

    typedef enum logic [1:0] {BTN_LEFT, BTN_RIGHT, BTN_CLEAR} btn_e;

    logic          clk;
    logic          pb_out_rst;
    logic          btn_left;
    logic          btn_right;
    logic          btn_clear;
    bar_pkg::led_t led;

    btn_e          row_btn[MAX_ROWS];
    logic          row_glitch[MAX_ROWS];
    bar_pkg::led_t row_exp[MAX_ROWS];
    int            num_rows;
    bit            table_ready;  // set once every row is in
    int            model_level;  // reference fill level
    integer        seed;

    led_bar_top dut (
        .clk        (clk),
        .pb_out_rst (pb_out_rst),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_clear  (btn_clear),
        .led        (led)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // top lvl bits lit from bit 15 down
    function automatic bar_pkg::led_t bar_of_level(input int lvl);
        bar_pkg::led_t pat;
        pat = '0;
        for (int i = 0; i < lvl; i++) begin
            pat[`BAR_WIDTH-1-i] = 1'b1;
        end
        return pat;
    endfunction

    task automatic add_row(input btn_e btn, input logic glitch);
        case (btn)
            BTN_LEFT: begin
                if (model_level < `BAR_WIDTH) model_level++; // saturates full
            end
            BTN_RIGHT: begin
                if (model_level > 0) model_level--;
            end
            default: begin
                model_level = 0;
            end
        endcase
        row_btn[num_rows]    = btn;
        row_glitch[num_rows] = glitch;
        row_exp[num_rows]    = bar_of_level(model_level);
        num_rows++;
    endtask

    task automatic build_table();
        model_level = 0;
        num_rows    = 0;
        repeat (`BAR_WIDTH + 1) add_row(BTN_LEFT, 1'b0);  // last one saturates
        repeat (`BAR_WIDTH + 1) add_row(BTN_RIGHT, 1'b0); // last one at empty
        add_row(BTN_LEFT, 1'b0);
        add_row(BTN_LEFT, 1'b0);
        add_row(BTN_LEFT, 1'b0);
        add_row(BTN_RIGHT, 1'b0);
        add_row(BTN_LEFT, 1'b0);
        add_row(BTN_CLEAR, 1'b0);
        // bouncy presses
        add_row(BTN_LEFT, 1'b1);
        add_row(BTN_RIGHT, 1'b1);
        add_row(BTN_LEFT, 1'b0);
        add_row(BTN_LEFT, 1'b0);
        add_row(BTN_CLEAR, 1'b1);
        add_row(BTN_LEFT, 1'b1);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic set_button(input btn_e btn, input logic value);
        case (btn)
            BTN_LEFT:  btn_left  = value;
            BTN_RIGHT: btn_right = value;
            default:   btn_clear = value;
        endcase
    endtask

    task automatic press_button(input btn_e btn);
        set_button(btn, 1'b1);
        wait_cycles(HOLD);
        set_button(btn, 1'b0);
        wait_cycles(HOLD);
    endtask

    task automatic glitch_button(input btn_e btn);
        int high_len;
        int gap_len;
        repeat (GLITCHES) begin
            high_len = 1 + ({$random(seed)} % (DEPTH - 1)); // always short of DEPTH
            gap_len  = 1 + ({$random(seed)} % DEPTH);
            set_button(btn, 1'b1);
            wait_cycles(high_len);
            set_button(btn, 1'b0);
            wait_cycles(gap_len);
        end
        wait_cycles(DEPTH + 2); // let any false pulse reach led
    endtask

    task automatic check_led(input bar_pkg::led_t exp);
        if (led !== exp) begin
            $display("MISMATCH time=%0t signal=led expected=%h actual=%h", $time, exp, led);
            $display("TEST FAIL");
            $fatal(1, "led compare failed");
        end
    endtask

    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = 2 * (RST_CYCLES + num_rows * ROW_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        $display("run timed out after %0d ns", limit_ns);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        bar_pkg::led_t prev_exp;
        clk        = 1'b0;
        pb_out_rst = 1'b1;
        btn_left   = 1'b0;
        btn_right  = 1'b0;
        btn_clear  = 1'b0;
        seed       = 35;
        build_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        pb_out_rst = 1'b0;
        wait_cycles(2);
        check_led('0);
        prev_exp = '0;
        for (int r = 0; r < num_rows; r++) begin
            if (row_glitch[r]) begin
                glitch_button(row_btn[r]);
                check_led(prev_exp); // glitches alone leave the bar as it was
            end
            press_button(row_btn[r]);
            check_led(row_exp[r]);
            prev_exp = row_exp[r];
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+logic
logic/bar_pkg.sv
logic/button_conditioner.sv
logic/led_bar_ctrl.sv
logic/led_bar_top.sv
dv/led_bar_sva.sv
dv/led_bar_tb.sv

// File: logic/bar_params.svh
`ifndef BAR_PARAMS_SVH
`define BAR_PARAMS_SVH

// leds on the bar, filled from the top bit down
`define BAR_WIDTH 16

// equal raw samples needed before a new level is accepted
`define DEBOUNCE_DEPTH 4

`endif

// File: logic/bar_pkg.sv
`default_nettype none

`include "bar_params.svh"

package bar_pkg;

    // one bit per led, bit 15 lights first
    typedef logic [`BAR_WIDTH-1:0] led_t;

    // 0 to BAR_WIDTH inclusive
    typedef logic [$clog2(`BAR_WIDTH+1)-1:0] level_t;

    typedef enum logic [1:0] {
        BAR_INIT    = 2'd0, // loads an empty bar
        BAR_EMPTY   = 2'd1, // level 0, left only
        BAR_PARTIAL = 2'd2, // both directions
        BAR_FULL    = 2'd3  // level BAR_WIDTH, right only
    } bar_state_e;

endpackage

`default_nettype wire

// File: logic/button_conditioner.sv
`default_nettype none

`include "bar_params.svh"

// debounce by sampling, then one pulse per clean press
module button_conditioner #(
    parameter int DEPTH = `DEBOUNCE_DEPTH
) (
    input  logic clk,
    input  logic pb_out_rst,
    input  logic pb,
    output logic pulse
);

    logic [DEPTH-1:0] samples;  // newest at bit 0
    logic             all_high;
    logic             all_low;
    logic             level;    // debounced button
    logic             level_q;  // level one cycle back

    // raw input is asynchronous, the shift chain also syncs it
    always_ff @(posedge clk or posedge pb_out_rst) begin
        if (pb_out_rst) begin
            samples <= '0;
        end else begin
            samples <= {samples[DEPTH-2:0], pb};
        end
    end

    assign all_high = &samples;
    assign all_low  = ~|samples;

    // level only moves once every sample agrees
    always_ff @(posedge clk or posedge pb_out_rst) begin
        if (pb_out_rst) begin
            level <= 1'b0;
        end else if (all_high) begin
            level <= 1'b1;
        end else if (all_low) begin
            level <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge pb_out_rst) begin
        if (pb_out_rst) begin
            level_q <= 1'b0;
        end else begin
            level_q <= level;
        end
    end

    // rising edge of level, registered
    always_ff @(posedge clk or posedge pb_out_rst) begin
        if (pb_out_rst) begin
            pulse <= 1'b0;
        end else begin
            pulse <= level & ~level_q; // release gives nothing
        end
    end

endmodule

`default_nettype wire

// File: logic/led_bar_ctrl.sv
`default_nettype none

`include "bar_params.svh"

module led_bar_ctrl (
    input  logic          clk,
    input  logic          pb_out_rst,
    input  logic          press_left,
    input  logic          press_right,
    input  logic          press_clear,
    output bar_pkg::led_t led
);

    localparam int IDX_W = $clog2(`BAR_WIDTH);
    localparam bar_pkg::level_t FULL_LEVEL = bar_pkg::level_t'(`BAR_WIDTH);

    bar_pkg::bar_state_e state;
    bar_pkg::bar_state_e next_state;
    bar_pkg::level_t     level;
    bar_pkg::level_t     next_level;
    bar_pkg::led_t       next_led;
    logic [IDX_W-1:0]    bit_idx;   // led touched this cycle
    logic                wipe;
    logic                grow;
    logic                shrink;

    // state always follows the level
    function automatic bar_pkg::bar_state_e state_of(input bar_pkg::level_t lvl);
        bar_pkg::bar_state_e st;
        if (lvl == '0) begin
            st = bar_pkg::BAR_EMPTY;
        end else if (lvl == FULL_LEVEL) begin
            st = bar_pkg::BAR_FULL;
        end else begin
            st = bar_pkg::BAR_PARTIAL;
        end
        return st;
    endfunction

    always_ff @(posedge clk or posedge pb_out_rst) begin
        if (pb_out_rst) begin
            state <= bar_pkg::BAR_INIT;
        end else begin
            state <= next_state;
        end
    end

    // which presses count in this state
    // clear beats left, left beats right
    always_comb begin
        wipe   = 1'b0;
        grow   = 1'b0;
        shrink = 1'b0;
        case (state)
            bar_pkg::BAR_INIT: begin
                wipe = 1'b1;
            end
            bar_pkg::BAR_EMPTY: begin
                wipe = press_clear;
                grow = press_left & ~press_clear; // right ignored
            end
            bar_pkg::BAR_PARTIAL: begin
                wipe   = press_clear;
                grow   = press_left & ~press_clear;
                shrink = press_right & ~press_left & ~press_clear;
            end
            bar_pkg::BAR_FULL: begin
                wipe   = press_clear;
                shrink = press_right & ~press_clear; // left saturates
            end
            default: begin
                wipe = 1'b1;
            end
        endcase
    end

    // next level and bar pattern
    always_comb begin
        next_level = level;
        next_led   = led;
        bit_idx    = '0;
        if (wipe) begin
            next_level = '0;
            next_led   = '0;
        end else if (grow) begin
            next_level = level + 1'b1;
            bit_idx    = IDX_W'(`BAR_WIDTH - next_level); // lowest lit bit
            next_led[bit_idx] = 1'b1;
        end else if (shrink) begin
            bit_idx    = IDX_W'(`BAR_WIDTH - level); // most recent led
            next_level = level - 1'b1;
            next_led[bit_idx] = 1'b0;
        end
        next_state = state_of(next_level);
    end

    always_ff @(posedge clk or posedge pb_out_rst) begin
        if (pb_out_rst) begin
            level <= '0;
            led   <= '0;
        end else begin
            level <= next_level;
            led   <= next_led;
        end
    end

endmodule

`default_nettype wire

// File: logic/led_bar_top.sv
`default_nettype none

`include "bar_params.svh"

module led_bar_top (
    input  logic          clk,
    input  logic          pb_out_rst,
    input  logic          btn_left,
    input  logic          btn_right,
    input  logic          btn_clear,
    output bar_pkg::led_t led
);

    // one cycle high per accepted press
    logic press_left;
    logic press_right;
    logic press_clear;

    button_conditioner #(
        .DEPTH(`DEBOUNCE_DEPTH)
    ) u_cond_left (
        .clk        (clk),
        .pb_out_rst (pb_out_rst),
        .pb         (btn_left),
        .pulse      (press_left)
    );

    button_conditioner #(
        .DEPTH(`DEBOUNCE_DEPTH)
    ) u_cond_right (
        .clk        (clk),
        .pb_out_rst (pb_out_rst),
        .pb         (btn_right),
        .pulse      (press_right)
    );

    // clear is a plain button, not a reset
    button_conditioner #(
        .DEPTH(`DEBOUNCE_DEPTH)
    ) u_cond_clear (
        .clk        (clk),
        .pb_out_rst (pb_out_rst),
        .pb         (btn_clear),
        .pulse      (press_clear)
    );

    led_bar_ctrl u_ctrl (
        .clk         (clk),
        .pb_out_rst  (pb_out_rst),
        .press_left  (press_left),
        .press_right (press_right),
        .press_clear (press_clear),
        .led         (led)
    );

endmodule

`default_nettype wire
